//--- project.f
rtl/chimePkg.sv
rtl/spiSongReceiver.sv
rtl/noteSequencer.sv
rtl/noteTimer.sv
rtl/toneGenerator.sv
rtl/chimeTop.sv
tests/tbChimeTop.sv

//--- rtl/chimePkg.sv
// shared types and lookup tables for the doorbell chime player
// song word layout, note fields and the tone / beat tables
`default_nettype none

package chimePkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int songWidth       = 40;  // one spi frame
	localparam int toneCodeWidth   = 4;
	localparam int durCodeWidth    = 4;
	localparam int halfPeriodWidth = 17;  // holds 54544
	localparam int beatCountWidth  = 3;   // up to 4 beats

	////////////////////////////////////////
	// song word
	////////////////////////////////////////

	typedef struct packed {
		logic [toneCodeWidth-1:0] toneCode;
		logic [durCodeWidth-1:0]  durCode;
	} note_t;

	// notes[0] sits in the msbs and plays first
	typedef struct packed {
		note_t [0:3] notes;
		logic [7:0]  repeatCount;  // extra passes through all four notes
	} songWord_t;

	////////////////////////////////////////
	// lookup tables
	////////////////////////////////////////

	// half-period in int_osc cycles at 24 MHz
	function automatic logic [halfPeriodWidth-1:0] toneHalfPeriod(
		input logic [toneCodeWidth-1:0] code
	);
		logic [halfPeriodWidth-1:0] hp;
		case (code)
			4'd0:    hp = 17'd54544;  // A3
			4'd1:    hp = 17'd48582;  // B3
			4'd2:    hp = 17'd45801;  // C4
			4'd3:    hp = 17'd40815;  // D4
			4'd4:    hp = 17'd36363;  // E4
			4'd5:    hp = 17'd34383;  // F4
			4'd6:    hp = 17'd30611;  // G4
			4'd7:    hp = 17'd27272;  // A4
			4'd8:    hp = 17'd24290;  // B4
			4'd9:    hp = 17'd22944;  // C5
			4'd10:   hp = 17'd20442;  // D5
			4'd11:   hp = 17'd18208;  // E5
			4'd12:   hp = 17'd17191;  // F5
			4'd13:   hp = 17'd15305;  // G5
			4'd14:   hp = 17'd13635;  // A5
			default: hp = 17'd27272;  // spare code plays A4
		endcase
		return hp;
	endfunction

	// beats per note from the duration code
	function automatic logic [beatCountWidth-1:0] noteBeats(
		input logic [durCodeWidth-1:0] code
	);
		logic [beatCountWidth-1:0] beats;
		if (code <= 4'd4) begin
			beats = 3'd4;  // whole
		end else if (code <= 4'd10) begin
			beats = 3'd2;  // half
		end else begin
			beats = 3'd1;  // quarter
		end
		return beats;
	endfunction

endpackage

`default_nettype wire

//--- rtl/chimeTop.sv
// top level of the doorbell chime player
// spi receiver feeds the sequencer which drives the note timer and tone generator
`default_nettype none

module chimeTop #(
	parameter int beatCycles = 6000000  // quarter second at 24 MHz
) (
	input  wire logic int_osc,
	input  wire logic rstN,
	input  wire logic sck,
	input  wire logic sdi,
	input  wire logic ce,
	output logic      pwm,
	output logic      playing
);
	import chimePkg::*;

	// handshake
	songWord_t song;
	logic      songReq;
	logic      songAck;

	// note control
	note_t curNote;
	logic  noteStart;
	logic  noteDone;
	logic  sounding;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	spiSongReceiver u_spiSongReceiver (
		.int_osc (int_osc),
		.rstN    (rstN),
		.sck     (sck),
		.sdi     (sdi),
		.ce      (ce),
		.playing (playing),
		.songAck (songAck),
		.songReq (songReq),
		.song    (song)
	);

	noteSequencer u_noteSequencer (
		.int_osc   (int_osc),
		.rstN      (rstN),
		.songReq   (songReq),
		.noteDone  (noteDone),
		.song      (song),
		.songAck   (songAck),
		.noteStart (noteStart),
		.sounding  (sounding),
		.playing   (playing),
		.curNote   (curNote)
	);

	noteTimer #(
		.beatCycles (beatCycles)
	) u_noteTimer (
		.int_osc   (int_osc),
		.rstN      (rstN),
		.noteStart (noteStart),
		.curNote   (curNote),
		.noteDone  (noteDone)
	);

	toneGenerator u_toneGenerator (
		.int_osc   (int_osc),
		.rstN      (rstN),
		.noteStart (noteStart),
		.sounding  (sounding),
		.curNote   (curNote),
		.pwm       (pwm)
	);

endmodule

`default_nettype wire

//--- rtl/noteSequencer.sv
// song sequencer FSM
// accepts a song over req/ack then plays its four notes repeatCount+1 times
// pulses noteStart per note and holds playing for the whole song
`default_nettype none

module noteSequencer (
	input  wire logic                 int_osc,
	input  wire logic                 rstN,
	input  wire logic                 songReq,
	input  wire logic                 noteDone,  // from the timer
	input  wire chimePkg::songWord_t  song,
	output logic                      songAck,
	output logic                      noteStart,
	output logic                      sounding,  // tone enable
	output logic                      playing,
	output chimePkg::note_t           curNote
);
	import chimePkg::*;

	typedef enum logic [1:0] {
		idle,
		ackWait,
		notePlay,
		finish
	} seqState_t;

	seqState_t  state;
	songWord_t  songReg;   // accepted song
	logic [1:0] noteIdx;   // 0 is the first note
	logic [7:0] repLeft;   // passes still to go

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge int_osc or negedge rstN) begin
		if (!rstN) begin
			state     <= idle;
			songAck   <= 1'b0;
			noteStart <= 1'b0;
			sounding  <= 1'b0;
			playing   <= 1'b0;
			noteIdx   <= 2'd0;
			repLeft   <= 8'd0;
		end else begin
			noteStart <= 1'b0;  // single-cycle pulse
			case (state)
				idle: begin
					if (songReq) begin
						songAck <= 1'b1;  // song taken this cycle
						state   <= ackWait;
					end
				end
				ackWait: begin
					// wait for req to drop then start the first note
					if (!songReq) begin
						songAck   <= 1'b0;
						noteIdx   <= 2'd0;
						repLeft   <= songReg.repeatCount;
						noteStart <= 1'b1;
						sounding  <= 1'b1;
						playing   <= 1'b1;
						state     <= notePlay;
					end
				end
				notePlay: begin
					if (noteDone) begin
						if (noteIdx == 2'd3) begin
							if (repLeft == 8'd0) begin
								sounding <= 1'b0;  // last note over
								state    <= finish;
							end else begin
								repLeft   <= repLeft - 8'd1;
								noteIdx   <= 2'd0;  // wrap for the next pass
								noteStart <= 1'b1;
							end
						end else begin
							noteIdx   <= noteIdx + 2'd1;
							noteStart <= 1'b1;  // back to back
						end
					end
				end
				finish: begin
					playing <= 1'b0;  // one trailing cycle
					state   <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// payload capture on the ack cycle
	always_ff @(posedge int_osc) begin
		if (state == idle && songReq) begin
			songReg <= song;
		end
	end

	assign curNote = songReg.notes[noteIdx];

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	ackFollowsReq: assert property (
		@(posedge int_osc) disable iff (!rstN)
		$rose(songAck) |-> songReq
	) else $error("songAck raised without songReq");

	doneOnlyWhileSounding: assert property (
		@(posedge int_osc) disable iff (!rstN)
		noteDone |-> sounding
	) else $error("noteDone while no note sounds");

endmodule

`default_nettype wire

//--- rtl/noteTimer.sv
// note length timer
// beats of beatCycles int_osc cycles each and noteDone on the last cycle
`default_nettype none

module noteTimer #(
	parameter int beatCycles = 6000000  // int_osc cycles per beat
) (
	input  wire logic             int_osc,
	input  wire logic             rstN,
	input  wire logic             noteStart,
	input  wire chimePkg::note_t  curNote,
	output logic                  noteDone
);
	import chimePkg::*;

	logic                         active;
	logic [beatCountWidth-1:0]    beatLeft;  // includes the current beat
	logic [$clog2(beatCycles)-1:0] cycCnt;   // cycle within the beat
	logic                         lastCycle;

	assign lastCycle = (cycCnt == ($bits(cycCnt))'(beatCycles - 1));

	// last cycle of last beat
	assign noteDone = active && lastCycle && (beatLeft == beatCountWidth'(1));

	always_ff @(posedge int_osc or negedge rstN) begin
		if (!rstN) begin
			active   <= 1'b0;
			beatLeft <= '0;
			cycCnt   <= '0;
		end else if (noteStart) begin
			active   <= 1'b1;
			beatLeft <= noteBeats(curNote.durCode);
			cycCnt   <= ($bits(cycCnt))'(1);  // start cycle already spent
		end else if (noteDone) begin
			active <= 1'b0;  // wait for the next start
		end else if (active) begin
			if (lastCycle) begin
				cycCnt   <= '0;
				beatLeft <= beatLeft - 1'b1;  // next beat
			end else begin
				cycCnt <= cycCnt + 1'b1;
			end
		end
	end

	// a note is always at least beatCycles long
	startDoneApart: assert property (
		@(posedge int_osc) disable iff (!rstN)
		!(noteDone && noteStart)
	) else $error("noteDone together with noteStart");

endmodule

`default_nettype wire

//--- rtl/spiSongReceiver.sv
// spi mode 0 song receiver
// shifts the 40-bit word in on sck and hands it over on the falling edge of ce
// the word goes to the sequencer through a four-phase req/ack handshake
`default_nettype none

module spiSongReceiver (
	input  wire logic               int_osc,
	input  wire logic               rstN,
	input  wire logic               sck,
	input  wire logic               sdi,
	input  wire logic               ce,
	input  wire logic               playing,  // busy flag from the sequencer
	input  wire logic               songAck,
	output logic                    songReq,
	output chimePkg::songWord_t     song
);
	import chimePkg::*;

	logic [songWidth-1:0] shiftReg;  // sck domain
	logic ceMeta;
	logic ceSync;
	logic ceLast;
	logic frameEnd;
	logic take;

	////////////////////////////////////////
	// sck domain shift-in
	////////////////////////////////////////

	// msb first while framed
	always_ff @(posedge sck) begin
		if (ce) begin
			shiftReg <= {shiftReg[songWidth-2:0], sdi};
		end
	end

	////////////////////////////////////////
	// ce sync and edge detect
	////////////////////////////////////////

	always_ff @(posedge int_osc or negedge rstN) begin
		if (!rstN) begin
			ceMeta <= 1'b0;
			ceSync <= 1'b0;
			ceLast <= 1'b0;
		end else begin
			ceMeta <= ce;      // first stage
			ceSync <= ceMeta;  // safe to use
			ceLast <= ceSync;  // for the edge
		end
	end

	assign frameEnd = ceLast & ~ceSync;  // ce just dropped

	// sck idles once ce is low so shiftReg is quiet here
	// drop the frame if a song is pending or playing
	assign take = frameEnd && !songReq && !songAck && !playing;

	////////////////////////////////////////
	// requester side of the handshake
	////////////////////////////////////////

	always_ff @(posedge int_osc or negedge rstN) begin
		if (!rstN) begin
			songReq <= 1'b0;
		end else if (songReq) begin
			if (songAck) begin
				songReq <= 1'b0;  // phase 2 seen
			end
		end else if (take) begin
			songReq <= 1'b1;
		end
	end

	// payload register
	always_ff @(posedge int_osc) begin
		if (take) begin
			song <= songWord_t'(shiftReg);
		end
	end

	// the sequencer may sample song on any cycle of the request
	songStableDuringReq: assert property (
		@(posedge int_osc) disable iff (!rstN)
		songReq |=> (!songReq || $stable(song))
	) else $error("song changed while songReq was high");

endmodule

`default_nettype wire

//--- rtl/toneGenerator.sv
// square wave for the current note
// pwm toggles every half-period+1 cycles while sounding and idles low
`default_nettype none

module toneGenerator (
	input  wire logic             int_osc,
	input  wire logic             rstN,
	input  wire logic             noteStart,
	input  wire logic             sounding,
	input  wire chimePkg::note_t  curNote,
	output logic                  pwm
);
	import chimePkg::*;

	logic [halfPeriodWidth-1:0] halfPeriod;  // latched per note
	logic [halfPeriodWidth-1:0] cnt;

	// table lookup on the start pulse
	always_ff @(posedge int_osc) begin
		if (noteStart) begin
			halfPeriod <= toneHalfPeriod(curNote.toneCode);
		end
	end

	always_ff @(posedge int_osc or negedge rstN) begin
		if (!rstN) begin
			cnt <= '0;
			pwm <= 1'b0;
		end else if (!sounding) begin
			cnt <= '0;  // silent
			pwm <= 1'b0;
		end else if (noteStart) begin
			// restart low and count the start cycle as the first one
			cnt <= halfPeriodWidth'(1);
			pwm <= 1'b0;
		end else if (cnt == halfPeriod) begin
			cnt <= '0;
			pwm <= ~pwm;  // half period done
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# compile and run the chime player testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbChimeTop \
	-f project.f \
	-o simChime

./obj_dir/simChime | tee sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

//--- tests/tbChimeTop.sv
// testbench for the doorbell chime player
// sends random songs over spi and checks start, length, first tone and idle pwm
// checking is done by concurrent assertions on a few measuring counters
`default_nettype none

module tbChimeTop;
	timeunit 1ns;
	timeprecision 100ps;

	import chimePkg::*;

	localparam int beatCycles = 10000;  // a whole note spans the slowest tone used
	localparam int clkPeriod  = 4;
	localparam int songCount  = 4;

	logic int_osc;
	logic rstN;
	logic sck;
	logic sdi;
	logic ce;
	logic pwm;
	logic playing;

	int     expLen;    // cycles playing should stay high
	int     expHalf;   // half-period of the first tone
	int     firstLen;  // cycles of the first note
	longint limitNs;

	logic ceLast;
	logic playLast;
	logic pwmLast;
	logic pending;      // idle frame sent, song not started yet
	int   sinceFrame;
	int   lenCnt;
	int   gap;          // cycles since playing rose or pwm toggled
	int   toneToggles;  // toggles seen in the first note

	int idleErrs = 0;
	int startErrs = 0;
	int lateErrs = 0;
	int lengthErrs = 0;
	int toneErrs = 0;
	int toggleErrs = 0;

	chimeTop #(
		.beatCycles (beatCycles)
	) u_chimeTop (
		.int_osc (int_osc),
		.rstN    (rstN),
		.sck     (sck),
		.sdi     (sdi),
		.ce      (ce),
		.pwm     (pwm),
		.playing (playing)
	);

	initial begin
		int_osc = 1'b0;
		forever #(clkPeriod / 2) int_osc = ~int_osc;
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic songWord_t randomSong(input logic [7:0] reps);
		songWord_t s;
		for (int n = 0; n < 4; n++) begin
			s.notes[n].toneCode = toneCodeWidth'($urandom % 16);
			s.notes[n].durCode  = durCodeWidth'($urandom % 16);
		end
		s.notes[0].toneCode = toneCodeWidth'(7 + $urandom % 9);  // A4 and up
		s.notes[0].durCode  = durCodeWidth'($urandom % 5);       // whole note
		s.repeatCount = reps;
		return s;
	endfunction

	function automatic int noteCycles(input note_t nt);
		return noteBeats(nt.durCode) * beatCycles;
	endfunction

	// all passes plus the trailing cycle
	function automatic int songCycles(input songWord_t s);
		int pass;
		pass = 0;
		for (int n = 0; n < 4; n++) begin
			pass += noteCycles(s.notes[n]);
		end
		return pass * (s.repeatCount + 1) + 1;
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(negedge int_osc);
	endtask

	// mode 0, msb first, sck at a quarter of int_osc
	task automatic shiftFrame(input songWord_t word);
		@(negedge int_osc);
		ce = 1'b1;
		for (int i = songWidth - 1; i >= 0; i--) begin
			sdi = word[i];
			waitCycles(2);
			sck = 1'b1;  // sampled here
			waitCycles(2);
			sck = 1'b0;
		end
		waitCycles(2);
		ce = 1'b0;  // frame end
	endtask

	////////////////////////////////////////
	// measuring counters
	////////////////////////////////////////

	always @(posedge int_osc or negedge rstN) begin
		if (!rstN) begin
			ceLast      <= 1'b0;
			playLast    <= 1'b0;
			pwmLast     <= 1'b0;
			pending     <= 1'b0;
			sinceFrame  <= 0;
			lenCnt      <= 0;
			gap         <= 0;
			toneToggles <= 0;
		end else begin
			ceLast   <= ce;
			playLast <= playing;
			pwmLast  <= pwm;
			if (ceLast && !ce && !playing) begin
				pending    <= 1'b1;  // only frames sent while idle count
				sinceFrame <= 1;
			end else if (pending) begin
				sinceFrame <= sinceFrame + 1;
				if (playing) begin
					pending <= 1'b0;
				end
			end
			if (playing && !playLast) begin
				lenCnt      <= 1;
				toneToggles <= 0;
			end else if (playing) begin
				lenCnt <= lenCnt + 1;
				if (pwm != pwmLast && lenCnt <= firstLen) begin
					toneToggles <= toneToggles + 1;
				end
			end
			if ((playing && !playLast) || pwm != pwmLast) begin
				gap <= 1;
			end else begin
				gap <= gap + 1;
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	idlePwmLow: assert property (@(posedge int_osc) disable iff (!rstN)
		!playing |-> !pwm
	) else begin
		idleErrs++;
		$display("FAILED t=%0t pwm expected 0 actual %0b while idle",
			$time, $sampled(pwm));
	end

	startNeedsFrame: assert property (@(posedge int_osc) disable iff (!rstN)
		$rose(playing) |-> pending
	) else begin
		startErrs++;
		$display("playing rose at t=%0t without a frame sent while idle", $time);
	end

	startInTime: assert property (@(posedge int_osc) disable iff (!rstN)
		pending |-> sinceFrame <= 8
	) else begin
		lateErrs++;
		$display("playing did not rise within 8 cycles of ce falling, t=%0t", $time);
	end

	songLength: assert property (@(posedge int_osc) disable iff (!rstN)
		$fell(playing) |-> lenCnt == expLen
	) else begin
		lengthErrs++;
		$display("FAILED t=%0t playing length expected %0d actual %0d",
			$time, expLen, $sampled(lenCnt));
	end

	// toggle spacing inside the first note
	firstTonePeriod: assert property (@(posedge int_osc) disable iff (!rstN)
		(playing && pwm != pwmLast && lenCnt <= firstLen) |-> gap == expHalf + 1
	) else begin
		toneErrs++;
		$display("FAILED t=%0t pwm half period expected %0d actual %0d",
			$time, expHalf + 1, $sampled(gap));
	end

	firstToneToggles: assert property (@(posedge int_osc) disable iff (!rstN)
		(playing && lenCnt == firstLen + 1) |-> toneToggles == firstLen / (expHalf + 1)
	) else begin
		toggleErrs++;
		$display("FAILED t=%0t pwm toggles in first note expected %0d actual %0d",
			$time, firstLen / (expHalf + 1), $sampled(toneToggles));
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		songWord_t songs [songCount];
		songWord_t noise;
		longint    budget;
		int        total;
		void'($urandom(42021));
		rstN     = 1'b0;
		ce       = 1'b0;
		sck      = 1'b0;
		sdi      = 1'b0;
		expLen   = 0;
		expHalf  = 0;
		firstLen = 0;
		limitNs  = 0;
		budget   = 2000;  // reset and quiet start
		for (int k = 0; k < songCount; k++) begin
			songs[k] = randomSong((k % 2 == 0) ? 8'd0 : 8'd2);
			budget += songCycles(songs[k]) + 1500;  // frames and idle gaps
		end
		limitNs = budget * clkPeriod;
		repeat (5) @(posedge int_osc);
		@(negedge int_osc);
		rstN = 1'b1;
		waitCycles(300);  // nothing may start here
		for (int k = 0; k < songCount; k++) begin
			expLen   = songCycles(songs[k]);
			expHalf  = toneHalfPeriod(songs[k].notes[0].toneCode);
			firstLen = noteCycles(songs[k].notes[0]);
			shiftFrame(songs[k]);
			while (!playing) @(negedge int_osc);
			if (k == 1 || k == 2) begin
				waitCycles(100);
				noise = randomSong(8'd5);
				shiftFrame(noise);  // must be dropped
			end
			while (playing) @(negedge int_osc);
			waitCycles(300);
		end
		total = idleErrs + startErrs + lateErrs + lengthErrs + toneErrs + toggleErrs;
		$display("errors: idle %0d start %0d late %0d length %0d tone %0d toggles %0d",
			idleErrs, startErrs, lateErrs, lengthErrs, toneErrs, toggleErrs);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog from the summed song lengths
	initial begin
		wait (limitNs != 0);
		#(limitNs);
		$display("timeout: songs did not finish within %0d ns", limitNs);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
